/* scrub_pkg.sv */
`default_nettype none

package scrub_pkg;

   // ----------------------------------------
   // Channel and address geometry
   // ----------------------------------------

   // Channel index 0..3 maps to DDR A, B, D, C
   localparam int NUM_DDR = 4;

   localparam int SCRB_ADDR_W = 64;
   localparam int SCRB_BURST_LEN_MINUS1 = 15;
   localparam int SCRB_BEAT_BYTES = 64;
   localparam int SCRB_BURST_BYTES = (SCRB_BURST_LEN_MINUS1 + 1) * SCRB_BEAT_BYTES;

   // Small range for simulation, eight bursts per channel
   localparam logic [SCRB_ADDR_W-1:0] SCRB_MAX_ADDR = 64'h0000_0000_0000_1FFF;

   // ----------------------------------------
   // Identity words
   // ----------------------------------------
   localparam logic [31:0] ID0_WORD = 32'h1D50_6789;
   localparam logic [31:0] ID1_WORD = 32'h1D51_FEDC;
   localparam logic [31:0] CL_VERSION = 32'hEEEE_EE00;
   localparam logic [19:0] STATUS_SIG = 20'hA_1111;

   typedef enum logic [2:0]
   {
      IDLE = 3'd0,
      RUN  = 3'd1,
      DONE = 3'd2
   } scrb_state_e;

   // Control word as written by the shell
   typedef struct packed
   {
      logic                dbg_en;
      logic [2:0]          dbg_sel;
      logic [23:0]         rsvd;
      logic [NUM_DDR-1:0]  scrb_en;
   } ctl_word_t;

   // Report of a single scrubber
   typedef struct packed
   {
      scrb_state_e             state;
      logic                    done;
      logic [SCRB_ADDR_W-1:0]  addr;
   } scrb_stat_t;

   typedef scrb_stat_t [NUM_DDR-1:0] scrb_stat_vec_t;

   typedef struct packed
   {
      logic         zero;
      scrb_state_e  state;
   } state_nib_t;

   // ----------------------------------------
   // Status0 word, normal and debug layouts
   // ----------------------------------------
   typedef struct packed
   {
      logic [19:0]         sig;
      logic [3:0]          zero;
      logic [NUM_DDR-1:0]  done;
      logic [NUM_DDR-1:0]  ready;
   } status_norm_t;

   typedef struct packed
   {
      state_nib_t [NUM_DDR-1:0]  nib;
      logic [7:0]                zero;
      logic [NUM_DDR-1:0]        done;
      logic [NUM_DDR-1:0]        ready;
   } status_dbg_t;

   typedef union packed
   {
      status_norm_t  norm;
      status_dbg_t   dbg;
   } status_word_u;

endpackage

`default_nettype wire

/* scrub_ctl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module scrub_ctl_regs
   import scrub_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                sync_rst_n,
   input  wire logic [31:0]         sh_cl_ctl0,
   input  wire logic [NUM_DDR-1:0]  ddr_is_ready,
   input  wire logic                flr_assert,
   output ctl_word_t                ctl_q,
   output logic [NUM_DDR-1:0]       ready_q,
   output logic                     flr_done
);

   logic flr_assert_q;

   // ----------------------------------------
   // Control word and ready flags
   // ----------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q <= '0;
         ready_q <= '0;
      end
      else
      begin
         ctl_q <= ctl_word_t'(sh_cl_ctl0);
         ready_q <= ddr_is_ready;
      end
   end

   // ----------------------------------------
   // FLR acknowledge
   // ----------------------------------------

   // A held request toggles done every other cycle
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done <= flr_assert_q && !flr_done;
      end
   end

endmodule

`default_nettype wire

/* ddr_scrubber.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_scrubber
   import scrub_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  sync_rst_n,
   input  wire logic  enable,
   input  wire logic  ddr_ready,
   output scrb_stat_t stat
);

   scrb_state_e             state_q;
   logic                    done_q;
   logic [SCRB_ADDR_W-1:0]  addr_q;
   logic [SCRB_ADDR_W-1:0]  addr_nxt;
   logic                    last_burst;

   // One burst worth of progress
   assign addr_nxt = addr_q + SCRB_ADDR_W'(SCRB_BURST_BYTES);

   // Step that carries the address past the end of the range
   assign last_burst = (addr_nxt > SCRB_MAX_ADDR);

   // ----------------------------------------
   // Sequencer
   // ----------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state_q <= IDLE;
         done_q <= 1'b0;
         addr_q <= '0;
      end
      else if (!enable)
      begin
         // Dropping enable abandons the pass from any state
         state_q <= IDLE;
         done_q <= 1'b0;
         addr_q <= '0;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               state_q <= RUN;
               addr_q <= '0;
            end
            RUN:
            begin
               // Channel not ready, hold where we are
               if (ddr_ready)
               begin
                  addr_q <= addr_nxt;
                  if (last_burst)
                  begin
                     state_q <= DONE;
                     done_q <= 1'b1;
                  end
               end
            end
            DONE:
            begin
               // Stay finished until enable falls
               done_q <= 1'b1;
            end
            default:
            begin
               state_q <= IDLE;
               done_q <= 1'b0;
               addr_q <= '0;
            end
         endcase
      end
   end

   assign stat.state = state_q;
   assign stat.done = done_q;
   assign stat.addr = addr_q;

endmodule

`default_nettype wire

/* status_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module status_readout
   import scrub_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                sync_rst_n,
   input  wire ctl_word_t           ctl_q,
   input  wire logic [NUM_DDR-1:0]  ready_q,
   input  wire scrb_stat_vec_t      scrb_stat,
   output logic [31:0]              cl_sh_status0,
   output logic [31:0]              cl_sh_id0,
   output logic [31:0]              cl_sh_id1
);

   status_word_u            status_nxt;
   logic [NUM_DDR-1:0]      done_vec;
   logic [1:0]              sel_ch;
   logic [SCRB_ADDR_W-1:0]  sel_addr;

   always_comb
   begin
      for (int i = 0; i < NUM_DDR; i++)
      begin
         done_vec[i] = scrb_stat[i].done;
      end
   end

   // ----------------------------------------
   // Status0 in either layout
   // ----------------------------------------
   always_comb
   begin
      status_nxt = '0;
      if (ctl_q.dbg_en)
      begin
         for (int i = 0; i < NUM_DDR; i++)
         begin
            status_nxt.dbg.nib[i].zero = 1'b0;
            status_nxt.dbg.nib[i].state = scrb_stat[i].state;
         end
         status_nxt.dbg.zero = '0;
         status_nxt.dbg.done = done_vec;
         status_nxt.dbg.ready = ready_q;
      end
      else
      begin
         status_nxt.norm.sig = STATUS_SIG;
         status_nxt.norm.zero = '0;
         status_nxt.norm.done = done_vec;
         status_nxt.norm.ready = ready_q;
      end
   end

   // Selects 4..7 fall back to channel 0
   assign sel_ch = ctl_q.dbg_sel[2] ? 2'd0 : ctl_q.dbg_sel[1:0];
   assign sel_addr = scrb_stat[sel_ch].addr;

   // ----------------------------------------
   // Registered read-back
   // ----------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         cl_sh_status0 <= '0;
         cl_sh_id0 <= '0;
         cl_sh_id1 <= '0;
      end
      else
      begin
         cl_sh_status0 <= status_nxt;
         cl_sh_id0 <= ctl_q.dbg_en ? sel_addr[31:0] : ID0_WORD;
         cl_sh_id1 <= ctl_q.dbg_en ? sel_addr[63:32] : ID1_WORD;
      end
   end

endmodule

`default_nettype wire

/* ddr_scrub_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_scrub_top
   import scrub_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                sync_rst_n,
   input  wire logic [31:0]         sh_cl_ctl0,
   input  wire logic [NUM_DDR-1:0]  ddr_is_ready,
   input  wire logic                flr_assert,
   output logic                     flr_done,
   output logic [31:0]              cl_sh_status0,
   output logic [31:0]              cl_sh_status1,
   output logic [31:0]              cl_sh_id0,
   output logic [31:0]              cl_sh_id1
);

   ctl_word_t           ctl_q;
   logic [NUM_DDR-1:0]  ready_q;
   scrb_stat_vec_t      scrb_stat;

   // ----------------------------------------
   // Control and FLR
   // ----------------------------------------
   scrub_ctl_regs scrub_ctl_regs_i
   (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .sh_cl_ctl0   (sh_cl_ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .ctl_q        (ctl_q),
      .ready_q      (ready_q),
      .flr_done     (flr_done)
   );

   // ----------------------------------------
   // Per-channel scrubbers
   // ----------------------------------------
   for (genvar g = 0; g < NUM_DDR; g++)
   begin : g_scrb
      ddr_scrubber ddr_scrubber_i
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (ctl_q.scrb_en[g]),
         .ddr_ready  (ready_q[g]),
         .stat       (scrb_stat[g])
      );
   end

   // ----------------------------------------
   // Read-back
   // ----------------------------------------
   status_readout status_readout_i
   (
      .clk           (clk),
      .sync_rst_n    (sync_rst_n),
      .ctl_q         (ctl_q),
      .ready_q       (ready_q),
      .scrb_stat     (scrb_stat),
      .cl_sh_status0 (cl_sh_status0),
      .cl_sh_id0     (cl_sh_id0),
      .cl_sh_id1     (cl_sh_id1)
   );

   // Version word never changes
   assign cl_sh_status1 = CL_VERSION;

endmodule

`default_nettype wire

/* ddr_scrub_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_scrub_checker
   import scrub_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                sync_rst_n,
   input  wire logic [31:0]         sh_cl_ctl0,
   input  wire logic [NUM_DDR-1:0]  ddr_is_ready,
   input  wire logic                flr_assert,
   input  wire logic                flr_done,
   input  wire logic [31:0]         cl_sh_status0,
   input  wire logic [31:0]         cl_sh_status1,
   input  wire logic [31:0]         cl_sh_id0,
   input  wire logic [31:0]         cl_sh_id1
);

   // One sample of the top-level inputs
   typedef struct packed
   {
      logic [31:0]         ctl;
      logic [NUM_DDR-1:0]  rdy;
      logic                flr;
   } in_smp_t;

   in_smp_t      smp_d1;
   in_smp_t      smp_d2;
   in_smp_t      smp_d3;
   logic         done_d1;
   logic [63:0]  id_d1;
   logic [1:0]   hist;
   logic [4:0]   all_on_cnt;

   // Channel shown in debug view where selects 4..7 read channel 0
   function automatic logic [1:0] sel_ch(input logic [31:0] ctl);
      return (ctl[30:28] < 3'd4) ? ctl[29:28] : 2'd0;
   endfunction

   task automatic flag_error(input string msg);
      tb_ddr_scrub.assert_fails++;
      $error("%s", msg);
   endtask

   // ----------------------------------------
   // Input history
   // ----------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         smp_d1 <= '0;
         smp_d2 <= '0;
         smp_d3 <= '0;
         done_d1 <= 1'b0;
         id_d1 <= '0;
         hist <= '0;
         all_on_cnt <= '0;
      end
      else
      begin
         smp_d1 <= '{ctl: sh_cl_ctl0, rdy: ddr_is_ready, flr: flr_assert};
         smp_d2 <= smp_d1;
         smp_d3 <= smp_d2;
         done_d1 <= flr_done;
         id_d1 <= {cl_sh_id1, cl_sh_id0};
         if (hist != 2'd3)
         begin
            hist <= hist + 2'd1;
         end
         // Run of cycles with every channel enabled and ready
         if (sh_cl_ctl0[NUM_DDR-1:0] == '1 && ddr_is_ready == '1)
         begin
            all_on_cnt <= (all_on_cnt == 5'd31) ? all_on_cnt : all_on_cnt + 5'd1;
         end
         else
         begin
            all_on_cnt <= '0;
         end
      end
   end

   // ----------------------------------------
   // Reset, version and normal view
   // ----------------------------------------
   a_version: assert property (@(posedge clk) cl_sh_status1 == CL_VERSION)
      else flag_error($sformatf("Error at %0t: cl_sh_status1 = %h, expected %h",
         $time, $sampled(cl_sh_status1), CL_VERSION));

   a_reset_zero: assert property (@(posedge clk) !sync_rst_n |->
      !flr_done && cl_sh_status0 == '0 && cl_sh_id0 == '0 && cl_sh_id1 == '0)
      else flag_error($sformatf(
         "Error at %0t: flr_done=%b cl_sh_status0=%h cl_sh_id0=%h cl_sh_id1=%h, expected 0",
         $time, $sampled(flr_done), $sampled(cl_sh_status0), $sampled(cl_sh_id0),
         $sampled(cl_sh_id1)));

   a_normal_view: assert property (@(posedge clk) disable iff (!sync_rst_n)
      hist >= 2 && !smp_d2.ctl[31] |-> cl_sh_id0 == ID0_WORD && cl_sh_id1 == ID1_WORD
      && cl_sh_status0[31:12] == STATUS_SIG)
      else flag_error($sformatf(
         "Error at %0t: cl_sh_id0=%h cl_sh_id1=%h cl_sh_status0[31:12]=%h, expected %h %h %h",
         $time, $sampled(cl_sh_id0), $sampled(cl_sh_id1), $sampled(cl_sh_status0[31:12]),
         ID0_WORD, ID1_WORD, STATUS_SIG));

   a_ready_nibble: assert property (@(posedge clk) disable iff (!sync_rst_n)
      hist >= 2 |-> cl_sh_status0[3:0] == smp_d2.rdy)
      else flag_error($sformatf("Error at %0t: cl_sh_status0[3:0] = %h, expected %h",
         $time, $sampled(cl_sh_status0[3:0]), $sampled(smp_d2.rdy)));

   // Done pulse from the request seen two edges back
   a_flr_pulse: assert property (@(posedge clk) disable iff (!sync_rst_n)
      hist >= 2 |-> flr_done == (smp_d2.flr && !done_d1))
      else flag_error($sformatf("Error at %0t: flr_done = %b, expected %b",
         $time, $sampled(flr_done), $sampled(smp_d2.flr && !done_d1)));

   a_all_done: assert property (@(posedge clk) disable iff (!sync_rst_n)
      all_on_cnt >= 16 |-> cl_sh_status0[7:4] == 4'hF)
      else flag_error($sformatf("Error at %0t: cl_sh_status0[7:4] = %h, expected f",
         $time, $sampled(cl_sh_status0[7:4])));

   // ----------------------------------------
   // Debug address read-back
   // ----------------------------------------
   a_dbg_addr_range: assert property (@(posedge clk) disable iff (!sync_rst_n)
      hist >= 2 && smp_d2.ctl[31] |-> {cl_sh_id1, cl_sh_id0} % SCRB_BURST_BYTES == 0
      && {cl_sh_id1, cl_sh_id0} <= SCRB_MAX_ADDR + 1)
      else flag_error($sformatf("Error at %0t: debug address %h is off the burst grid or range",
         $time, $sampled({cl_sh_id1, cl_sh_id0})));

   a_dbg_done_addr: assert property (@(posedge clk) disable iff (!sync_rst_n)
      hist >= 2 && smp_d2.ctl[31] && cl_sh_status0[4 + sel_ch(smp_d2.ctl)]
      |-> cl_sh_id0 == 32'h0000_2000 && cl_sh_id1 == '0)
      else flag_error($sformatf("Error at %0t: {cl_sh_id1, cl_sh_id0} = %h, expected %h",
         $time, $sampled({cl_sh_id1, cl_sh_id0}), 64'h0000_0000_0000_2000));

   // A stalled channel keeps its address between reads
   a_stall_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      hist == 3 && smp_d2.ctl[31] && smp_d3.ctl[31]
      && sel_ch(smp_d2.ctl) == sel_ch(smp_d3.ctl) && smp_d3.ctl[sel_ch(smp_d3.ctl)]
      && !smp_d3.rdy[sel_ch(smp_d3.ctl)] |-> {cl_sh_id1, cl_sh_id0} == id_d1)
      else flag_error($sformatf("Error at %0t: debug address = %h, expected %h",
         $time, $sampled({cl_sh_id1, cl_sh_id0}), $sampled(id_d1)));

   // ----------------------------------------
   // Per-channel done, state and disable
   // ----------------------------------------
   for (genvar i = 0; i < NUM_DDR; i++)
   begin : g_ch
      a_done_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
         hist >= 2 && cl_sh_status0[4+i] && smp_d2.ctl[i] |=> cl_sh_status0[4+i])
         else flag_error($sformatf("Error at %0t: done bit %0d fell while enabled",
            $time, i));

      a_done_nibble: assert property (@(posedge clk) disable iff (!sync_rst_n)
         hist >= 2 && smp_d2.ctl[31] && cl_sh_status0[4+i]
         |-> cl_sh_status0[16+4*i +: 4] == {1'b0, DONE})
         else flag_error($sformatf("Error at %0t: state nibble %0d = %h, expected 2",
            $time, i, $sampled(cl_sh_status0[16+4*i +: 4])));

      a_disable: assert property (@(posedge clk) disable iff (!sync_rst_n)
         hist == 3 && !smp_d3.ctl[i] |-> !cl_sh_status0[4+i] && (!smp_d2.ctl[31]
         || (cl_sh_status0[16+4*i +: 4] == {1'b0, IDLE}
         && (sel_ch(smp_d2.ctl) != 2'(i) || {cl_sh_id1, cl_sh_id0} == '0))))
         else flag_error($sformatf("Error at %0t: channel %0d not cleared, status0 = %h",
            $time, i, $sampled(cl_sh_status0)));
   end

endmodule

`default_nettype wire

/* tb_ddr_scrub.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_scrub
   import scrub_pkg::*;
();

   localparam int MAX_CYCLES = 2000;

   logic                clk;
   logic                sync_rst_n;
   logic [31:0]         sh_cl_ctl0;
   logic [NUM_DDR-1:0]  ddr_is_ready;
   logic                flr_assert;
   logic                flr_done;
   logic [31:0]         cl_sh_status0;
   logic [31:0]         cl_sh_status1;
   logic [31:0]         cl_sh_id0;
   logic [31:0]         cl_sh_id1;

   // Raised by the bound checker
   int assert_fails = 0;
   int timeouts = 0;
   int cycles = 0;

   ddr_scrub_top ddr_scrub_top_i (.*);

   bind ddr_scrub_top ddr_scrub_checker ddr_scrub_checker_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_and_finish();
      $display("Summary: %0d assertion failures, %0d timeouts", assert_fails, timeouts);
      if (assert_fails == 0 && timeouts == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   endtask

   // Watchdog
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         timeouts++;
         report_and_finish();
      end
   end

   // One cycle of random ready flags with the debug select stepping every third cycle
   task automatic drive_random_cycle(input int n);
      @(negedge clk);
      ddr_is_ready = 4'($urandom);
      sh_cl_ctl0[30:28] = 3'((n / 3) % 8);
   endtask

   task automatic random_until_done(input int tail);
      int n;
      n = 0;
      while (cl_sh_status0[7:4] != 4'hF)
      begin
         drive_random_cycle(n);
         n++;
      end
      repeat (tail)
      begin
         drive_random_cycle(n);
         n++;
      end
   endtask

   initial
   begin
      void'($urandom(23));
      sync_rst_n = 1'b1;
      sh_cl_ctl0 = '0;
      ddr_is_ready = '0;
      flr_assert = 1'b0;
      #2 sync_rst_n = 1'b0;
      repeat (2) @(negedge clk);
      sync_rst_n = 1'b1;

      // Normal view with wandering ready flags
      repeat (8)
      begin
         @(negedge clk);
         ddr_is_ready = 4'($urandom);
      end

      // Held FLR request followed by a single-cycle one
      flr_assert = 1'b1;
      repeat (8) @(negedge clk);
      flr_assert = 1'b0;
      repeat (3) @(negedge clk);
      flr_assert = 1'b1;
      @(negedge clk);
      flr_assert = 1'b0;
      repeat (4) @(negedge clk);

      // All channels enabled and ready
      sh_cl_ctl0 = ctl_word_t'{dbg_en: 1'b0, dbg_sel: 3'd0, rsvd: '0, scrb_en: 4'hF};
      ddr_is_ready = 4'hF;
      while (cl_sh_status0[7:4] != 4'hF)
      begin
         @(negedge clk);
      end
      repeat (20) @(negedge clk);

      // Debug view of finished channels through all eight selects
      sh_cl_ctl0[31] = 1'b1;
      for (int sel = 0; sel < 8; sel++)
      begin
         sh_cl_ctl0[30:28] = 3'(sel);
         repeat (3) @(negedge clk);
      end

      // Drop every enable and scrub again under back-pressure
      sh_cl_ctl0[NUM_DDR-1:0] = '0;
      repeat (4) @(negedge clk);
      sh_cl_ctl0[NUM_DDR-1:0] = '1;
      random_until_done(12);

      // Disable channels one at a time while watching each
      ddr_is_ready = 4'hF;
      for (int ch = 0; ch < NUM_DDR; ch++)
      begin
         sh_cl_ctl0[30:28] = 3'(ch);
         sh_cl_ctl0[ch] = 1'b0;
         repeat (5) @(negedge clk);
         // Only channel 0 is cleared here, so the high selects must read it
         if (ch == 0)
         begin
            for (int sel = 4; sel < 8; sel++)
            begin
               sh_cl_ctl0[30:28] = 3'(sel);
               repeat (3) @(negedge clk);
            end
         end
      end

      sh_cl_ctl0[31] = 1'b0;
      repeat (4) @(negedge clk);
      report_and_finish();
   end

endmodule

`default_nettype wire

/* all.f */
scrub_pkg.sv
scrub_ctl_regs.sv
ddr_scrubber.sv
status_readout.sv
ddr_scrub_top.sv
ddr_scrub_checker.sv
tb_ddr_scrub.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr_scrub \
   -f all.f -o tb_sim || { echo "Build failed"; exit 1; }

./obj_dir/tb_sim +verilator+error+limit+100000 > sim.log 2>&1
cat sim.log

! grep -q "=== FAIL ===" sim.log && grep -q "=== PASS ===" sim.log \
   && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
